/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_fpw
FILELIST := list.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all compile run check clean

all: check

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)

check: run
	@if grep -qF "*** TEST FAILED ***" $(LOG) || ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

/* fpw_chk.sv */
// Concurrent assertions on the wrapper handshakes and reset state
// Bound into fpw_top
`timescale 1ns/1ps

module fpw_chk
    import fpw_pkg::*;
(
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  flush_i,
    input logic                  cfg_req_i,
    input logic [FMT_CODE_W-1:0] cfg_wdata_i,
    input logic                  cfg_ack_o,
    input logic [FMT_CODE_W-1:0] cfg_fmt_code_o,
    input logic                  req_ready_o,
    input logic                  rsp_valid_o,
    input logic                  rsp_ready_i,
    input fpw_rsp_t              rsp_o
);

    // Stalled result keeps valid and data
    rsp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o && !rsp_ready_i && !flush_i |=> rsp_valid_o && $stable(rsp_o))
        else $error("result changed while stalled");

    // Ack answers a raised req and the field holds the written data
    ack_rise_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(cfg_ack_o) |-> $past(cfg_req_i) && (cfg_fmt_code_o == $past(cfg_wdata_i)))
        else $error("cfg ack rose without a req or without the write");

    // First edge out of reset
    reset_state_a: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> req_ready_o && !rsp_valid_o && !cfg_ack_o)
        else $error("wrong handshake state after reset");

endmodule

bind fpw_top fpw_chk i_fpw_chk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .cfg_req_i      (cfg_req_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_ack_o      (cfg_ack_o),
    .cfg_fmt_code_o (cfg_fmt_code_o),
    .req_ready_o    (req_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_o          (rsp_o)
);

/* fpw_format_csr.sv */
// Format configuration register for the sub-8-bit formats
// Written through a four-phase req/ack port
`timescale 1ns/1ps

module fpw_format_csr
    import fpw_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  cfg_req_i,
    input  logic [FMT_CODE_W-1:0] cfg_wdata_i,
    output logic                  cfg_ack_o,
    output fp_fmt_e               fmt_o,
    output logic [FMT_CODE_W-1:0] cfg_fmt_code_o
);

    logic [FMT_CODE_W-1:0] fmt_code_q;
    logic                  ack_q;

    // Ack follows req one edge late, the write happens on the rising phase
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fmt_code_q <= FMT_CODE_E5M2;
            ack_q      <= 1'b0;
        end else begin
            ack_q <= cfg_req_i;
            if (cfg_req_i && !ack_q) begin
                fmt_code_q <= cfg_wdata_i;  // New request, data is stable
            end
        end
    end

    // Code to format, unknown codes fall back to E5M2
    always_comb begin
        case (fmt_code_q)
            FMT_CODE_E4M3: fmt_o = E4M3;
            FMT_CODE_E2M1: fmt_o = E2M1;
            default:       fmt_o = E5M2;
        endcase
    end

    assign cfg_ack_o      = ack_q;
    assign cfg_fmt_code_o = fmt_code_q;

endmodule

/* fpw_issue_buffer.sv */
// Protocol inversion buffer between issue and the unit
// READY/STALL FSM with hold register and bypass mux
`timescale 1ns/1ps

module fpw_issue_buffer
    import fpw_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   flush_i,
    input  logic   in_valid_i,
    output logic   in_ready_o,
    input  issue_t issue_i,
    output logic   out_valid_o,
    input  logic   out_ready_i,
    output issue_t issue_o
);

    typedef enum logic {
        READY,
        STALL
    } buf_state_e;

    buf_state_e state_d, state_q;
    issue_t     hold_q;
    logic       hold_en;   // Capture the incoming item
    logic       use_hold;  // Drive the unit from the hold register

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        in_ready_o  = 1'b0;
        out_valid_o = 1'b0;
        hold_en     = 1'b0;
        use_hold    = 1'b0;
        state_d     = state_q;

        case (state_q)
            READY: begin
                in_ready_o  = 1'b1;        // Look ready to issue
                out_valid_o = in_valid_i;  // Forward valid as is
                // Unit busy, park the item in the hold register
                if (in_valid_i && !out_ready_i) begin
                    hold_en    = 1'b1;
                    state_d    = STALL;
                end
            end
            STALL: begin
                out_valid_o = 1'b1;
                use_hold    = 1'b1;
                if (out_ready_i) begin
                    state_d = READY;  // Held item taken
                end
            end
            default: ;
        endcase

        if (flush_i) begin
            state_d = READY;  // Flush drops the held item
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) state_q <= READY;
        else         state_q <= state_d;
    end

    always_ff @(posedge clk_i) begin
        if (hold_en) hold_q <= issue_i;
    end

    // Bypass mux
    assign issue_o = use_hold ? hold_q : issue_i;

endmodule

/* fpw_noncomp_unit.sv */
// Two-stage non-computational FP unit for E5M2, E4M3 and E2M1
// Stage 1 splits and classifies, stage 2 computes result and flags
// Sign injection, min/max, compare and classify with back-pressure
`timescale 1ns/1ps

module fpw_noncomp_unit
    import fpw_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  issue_t   issue_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output fpw_rsp_t rsp_o
);

    typedef struct packed {
        nc_op_e           op;
        fp_fmt_e          fmt;
        opnd_t            a;
        opnd_t            b;
        logic [TAG_W-1:0] tag;
    } stage1_t;

    logic     s1_valid_q, s2_valid_q;
    logic     s1_advance;  // Stage 2 empty or draining
    stage1_t  s1_d, s1_q;
    fpw_rsp_t rsp_d, rsp_q;

    // Split by format and classify
    function automatic opnd_t split_op(input logic [DATA_W-1:0] val, input fp_fmt_e fmt);
        opnd_t o;
        logic  exp_zero;
        logic  man_zero;
        logic  exp_max;
        o        = '0;
        o.sign   = val[7];
        o.mag    = val[6:0];
        case (fmt)
            E4M3: begin
                exp_zero   = ~|val[6:3];
                exp_max    = &val[6:3];
                man_zero   = ~|val[2:0];
                o.cls.qnan = exp_max & (&val[2:0]);  // S.1111.111 only
            end
            E2M1: begin
                o.sign   = val[3];  // Upper nibble ignored
                o.mag    = {{(MAG_W-3){1'b0}}, val[2:0]};
                exp_zero = ~|val[2:1];
                exp_max  = 1'b0;    // No inf or NaN
                man_zero = ~val[0];
            end
            default: begin  // E5M2
                exp_zero   = ~|val[6:2];
                exp_max    = &val[6:2];
                man_zero   = ~|val[1:0];
                o.cls.inf  = exp_max & man_zero;
                o.cls.qnan = exp_max & val[1];                // Quiet bit is mantissa MSB
                o.cls.snan = exp_max & ~val[1] & ~man_zero;
            end
        endcase
        o.cls.zero = exp_zero & man_zero;
        o.cls.subn = exp_zero & ~man_zero;
        o.cls.norm = ~exp_zero & ~(o.cls.inf | o.cls.qnan | o.cls.snan);
        return o;
    endfunction

    // Rebuild the operand encoding from sign and magnitude
    function automatic logic [RES_W-1:0] join_op(input logic sign, input logic [MAG_W-1:0] mag,
                                                 input fp_fmt_e fmt);
        if (fmt == E2M1) return RES_W'({sign, mag[2:0]});
        return RES_W'({sign, mag});
    endfunction

    // ----------------------------------------
    // Handshake and valids
    // ----------------------------------------
    assign s1_advance = !s2_valid_q || out_ready_i;
    assign in_ready_o = !s1_valid_q || s1_advance;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (in_ready_o) s1_valid_q <= in_valid_i;
            if (s1_advance) s2_valid_q <= s1_valid_q;  // Items hold place when blocked
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) s1_q  <= s1_d;
        if (s1_valid_q && s1_advance) rsp_q <= rsp_d;
    end

    // ----------------------------------------
    // Stage 1
    // ----------------------------------------
    always_comb begin
        s1_d.op  = issue_i.op;
        s1_d.fmt = issue_i.fmt;
        s1_d.a   = split_op(issue_i.operand_a, issue_i.fmt);
        s1_d.b   = split_op(issue_i.operand_b, issue_i.fmt);
        s1_d.tag = issue_i.tag;
    end

    // ----------------------------------------
    // Stage 2
    // ----------------------------------------
    always_comb begin
        logic             a_nan, b_nan, any_nan, any_snan;
        logic             both_zero, tot_lt, ieee_lt, ieee_eq;
        logic [RES_W-1:0] a_val, b_val, data;
        a_nan     = s1_q.a.cls.snan | s1_q.a.cls.qnan;
        b_nan     = s1_q.b.cls.snan | s1_q.b.cls.qnan;
        any_nan   = a_nan | b_nan;
        any_snan  = s1_q.a.cls.snan | s1_q.b.cls.snan;
        both_zero = s1_q.a.cls.zero & s1_q.b.cls.zero;
        a_val     = join_op(s1_q.a.sign, s1_q.a.mag, s1_q.fmt);
        b_val     = join_op(s1_q.b.sign, s1_q.b.mag, s1_q.fmt);

        // Total order, -0 below +0
        if (s1_q.a.sign != s1_q.b.sign) tot_lt = s1_q.a.sign;
        else if (s1_q.a.sign)           tot_lt = s1_q.b.mag < s1_q.a.mag;  // Both negative
        else                            tot_lt = s1_q.a.mag < s1_q.b.mag;
        ieee_lt = tot_lt & ~both_zero;  // Signed zeros compare equal
        ieee_eq = both_zero | ((s1_q.a.sign == s1_q.b.sign) && (s1_q.a.mag == s1_q.b.mag));

        data  = '0;
        rsp_d = '0;
        case (s1_q.op)
            SGNJ:  data = join_op(s1_q.b.sign, s1_q.a.mag, s1_q.fmt);
            SGNJN: data = join_op(~s1_q.b.sign, s1_q.a.mag, s1_q.fmt);
            SGNJX: data = join_op(s1_q.a.sign ^ s1_q.b.sign, s1_q.a.mag, s1_q.fmt);
            MIN, MAX: begin
                if (a_nan && b_nan) begin
                    data = RES_W'((s1_q.fmt == E4M3) ? CANON_NAN_E4M3 : CANON_NAN_E5M2);
                end else if (a_nan) begin
                    data = b_val;
                end else if (b_nan) begin
                    data = a_val;
                end else begin
                    data = (tot_lt ^ (s1_q.op == MAX)) ? a_val : b_val;
                end
                rsp_d.status.nv = any_snan;
            end
            LE: begin
                data[0]         = ~any_nan & (ieee_lt | ieee_eq);
                rsp_d.status.nv = any_nan;  // Signaling compare
            end
            LT: begin
                data[0]         = ~any_nan & ieee_lt;
                rsp_d.status.nv = any_nan;
            end
            EQ: begin
                data[0]         = ~any_nan & ieee_eq;
                rsp_d.status.nv = any_snan;  // Quiet compare
            end
            CLASS: begin
                data[0] = s1_q.a.sign & s1_q.a.cls.inf;
                data[1] = s1_q.a.sign & s1_q.a.cls.norm;
                data[2] = s1_q.a.sign & s1_q.a.cls.subn;
                data[3] = s1_q.a.sign & s1_q.a.cls.zero;
                data[4] = ~s1_q.a.sign & s1_q.a.cls.zero;
                data[5] = ~s1_q.a.sign & s1_q.a.cls.subn;
                data[6] = ~s1_q.a.sign & s1_q.a.cls.norm;
                data[7] = ~s1_q.a.sign & s1_q.a.cls.inf;
                data[8] = s1_q.a.cls.snan;
                data[9] = s1_q.a.cls.qnan;
            end
            default: ;
        endcase
        rsp_d.result = data;
        rsp_d.tag    = s1_q.tag;
    end

    assign out_valid_o = s2_valid_q;
    assign rsp_o       = rsp_q;

endmodule

/* fpw_op_decode.sv */
// Instruction decode into the unit opcode
// Attaches the configured format, operands and tag
`timescale 1ns/1ps

module fpw_op_decode
    import fpw_pkg::*;
(
    input  fpw_req_t req_i,
    input  fp_fmt_e  fmt_i,
    output issue_t   issue_o
);

    logic [1:0] rm_low;  // rm with the alternate-format bit dropped

    assign rm_low = req_i.rm[1:0];

    always_comb begin
        // Payload passes straight through
        issue_o.fmt       = fmt_i;
        issue_o.operand_a = req_i.operand_a;
        issue_o.operand_b = req_i.operand_b;
        issue_o.tag       = req_i.tag;
        issue_o.op        = SGNJ;  // Plain sign injection by default

        case (req_i.op)
            // Sign injection variant in rm
            FSGNJ: begin
                case (rm_low)
                    2'd1:    issue_o.op = SGNJN;
                    2'd2:    issue_o.op = SGNJX;
                    default: issue_o.op = SGNJ;   // rm 3 reads as plain SGNJ
                endcase
            end
            FMIN_MAX: issue_o.op = rm_low[0] ? MAX : MIN;
            // Compare variant in rm
            FCMP: begin
                case (rm_low)
                    2'd0:    issue_o.op = LE;
                    2'd1:    issue_o.op = LT;
                    default: issue_o.op = EQ;     // rm 3 reads as EQ
                endcase
            end
            FCLASS: issue_o.op = CLASS;
            default: ;
        endcase
    end

endmodule

/* fpw_pkg.sv */
// Shared widths, format codes and canonical NaN patterns
// Instruction, unit opcode and format enums
// Request, issue, operand class and response structs
package fpw_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned DATA_W     = 8;           // FP4 uses bits 3:0 only
    localparam int unsigned MAG_W      = DATA_W - 1;  // Operand without its sign
    localparam int unsigned RES_W      = 10;          // Sized for the class mask
    localparam int unsigned TAG_W      = 4;
    localparam int unsigned FMT_CODE_W = 4;

    // Codes held in the format config register
    localparam logic [FMT_CODE_W-1:0] FMT_CODE_E5M2 = 4'd1;
    localparam logic [FMT_CODE_W-1:0] FMT_CODE_E4M3 = 4'd2;
    localparam logic [FMT_CODE_W-1:0] FMT_CODE_E2M1 = 4'd5;

    // Canonical NaNs, E2M1 has none
    localparam logic [DATA_W-1:0] CANON_NAN_E5M2 = 8'h7E;
    localparam logic [DATA_W-1:0] CANON_NAN_E4M3 = 8'h7F;

    // ----------------------------------------
    // Enums
    // ----------------------------------------
    typedef enum logic [1:0] {
        E5M2,
        E4M3,
        E2M1
    } fp_fmt_e;

    // Instruction as issued, variant sits in rm
    typedef enum logic [1:0] {
        FSGNJ,
        FMIN_MAX,
        FCMP,
        FCLASS
    } fp_op_e;

    // Decoded unit opcode
    typedef enum logic [3:0] {
        SGNJ,
        SGNJN,
        SGNJX,
        MIN,
        MAX,
        LE,
        LT,
        EQ,
        CLASS
    } nc_op_e;

    // ----------------------------------------
    // Structs
    // ----------------------------------------
    typedef struct packed {
        logic nv;  // Invalid operation
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } status_t;

    typedef struct packed {
        fp_op_e             op;
        logic [2:0]         rm;         // Bit 2 is ignored by the decoder
        logic [DATA_W-1:0]  operand_a;
        logic [DATA_W-1:0]  operand_b;
        logic [TAG_W-1:0]   tag;
    } fpw_req_t;

    typedef struct packed {
        nc_op_e             op;
        fp_fmt_e            fmt;
        logic [DATA_W-1:0]  operand_a;
        logic [DATA_W-1:0]  operand_b;
        logic [TAG_W-1:0]   tag;
    } issue_t;

    typedef struct packed {
        logic [RES_W-1:0]   result;
        status_t            status;
        logic [TAG_W-1:0]   tag;
    } fpw_rsp_t;

    // One-hot operand class
    typedef struct packed {
        logic snan;
        logic qnan;
        logic inf;
        logic norm;
        logic subn;
        logic zero;
    } fp_class_t;

    // Operand after the format split
    typedef struct packed {
        logic              sign;
        logic [MAG_W-1:0]  mag;   // Exponent and mantissa, zero extended for E2M1
        fp_class_t         cls;
    } opnd_t;

endpackage

/* fpw_top.sv */
// Top level of the sub-8-bit FP issue wrapper
// Config register, decoder, hold buffer and non-computational unit
`timescale 1ns/1ps

module fpw_top
    import fpw_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    // Config port
    input  logic                  cfg_req_i,
    input  logic [FMT_CODE_W-1:0] cfg_wdata_i,
    output logic                  cfg_ack_o,
    output logic [FMT_CODE_W-1:0] cfg_fmt_code_o,
    // Request side
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  fpw_req_t              req_i,
    // Result side
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output fpw_rsp_t              rsp_o
);

    fp_fmt_e fmt;
    issue_t  issue_dec, unit_issue;
    logic    unit_valid, unit_ready;

    fpw_format_csr i_format_csr (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .cfg_req_i      (cfg_req_i),
        .cfg_wdata_i    (cfg_wdata_i),
        .cfg_ack_o      (cfg_ack_o),
        .fmt_o          (fmt),
        .cfg_fmt_code_o (cfg_fmt_code_o)
    );

    fpw_op_decode i_op_decode (
        .req_i   (req_i),
        .fmt_i   (fmt),
        .issue_o (issue_dec)
    );

    // Back-pressure from the unit stalls issue here
    fpw_issue_buffer i_issue_buffer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (req_valid_i),
        .in_ready_o  (req_ready_o),
        .issue_i     (issue_dec),
        .out_valid_o (unit_valid),
        .out_ready_i (unit_ready),
        .issue_o     (unit_issue)
    );

    fpw_noncomp_unit i_noncomp_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (unit_valid),
        .in_ready_o  (unit_ready),
        .issue_i     (unit_issue),
        .out_valid_o (rsp_valid_o),
        .out_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

endmodule

/* list.f */
fpw_pkg.sv
fpw_format_csr.sv
fpw_op_decode.sv
fpw_issue_buffer.sv
fpw_noncomp_unit.sv
fpw_top.sv
fpw_chk.sv
tb_fpw.sv

/* tb_fpw.sv */
// Testbench for the sub-8-bit FP issue wrapper
// LFSR stimulus, reference model, scoreboard with compare tasks
// Config writes, latency, back-pressure and flush checks
`timescale 1ns/1ps

module tb_fpw
    import fpw_pkg::*;
();

    localparam int N_PER     = 48;                          // Requests per format pass
    localparam int N_POST    = 8;                           // Requests after the flush
    localparam int N_CFG     = 11;                          // Config writes over all phases
    localparam int N_REQ     = 7 * N_PER + 3 + N_POST;
    localparam int TIMEOUT   = 4 * (N_REQ + N_CFG) + 200;   // In clock cycles
    localparam int C_ZERO    = 0;                           // Class codes of the model
    localparam int C_SUB     = 1;
    localparam int C_NORM    = 2;
    localparam int C_INF     = 3;
    localparam int C_SNAN    = 4;
    localparam int C_QNAN    = 5;
    localparam logic [FMT_CODE_W-1:0] CODES [4] = '{FMT_CODE_E5M2, FMT_CODE_E4M3,
                                                    FMT_CODE_E2M1, 4'd9};

    logic                  clk_i, rst_ni, flush_i;
    logic                  cfg_req_i, cfg_ack_o;
    logic [FMT_CODE_W-1:0] cfg_wdata_i, cfg_fmt_code_o;
    logic                  req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i;
    fpw_req_t              req_i;
    fpw_rsp_t              rsp_o;

    logic [31:0]           lfsr_q = 32'd72681;
    logic [FMT_CODE_W-1:0] cur_code;           // Format code the model assumes
    logic                  bp_mode, rsp_hold, lat_chk;
    int                    cycle = 0;
    int                    err_cnt = 0;
    int                    issue_cyc;
    fpw_rsp_t              exp_q [$];          // Expected responses in issue order
    int                    cyc_q [$];          // Issue cycle of each entry

    fpw_top i_fpw_top (.*);

    // ----------------------------------------
    // Clock, cycle count, timeout
    // ----------------------------------------
    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle++;
        if (cycle >= TIMEOUT) fail_run("timeout: the run did not finish in time");
    end

    // ----------------------------------------
    // Random numbers
    // ----------------------------------------
    function automatic logic lfsr_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);  // x^32+x^22+x^2+x+1
        return b;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[6:0], lfsr_bit()};
        return v;
    endfunction

    // Mostly random bytes, some zeros, subnormals, inf and NaN
    function automatic logic [DATA_W-1:0] rand_operand();
        if (rand_bits(2) != 8'd0) return rand_bits(8);
        case (rand_bits(3))
            8'd0:    return 8'h00;
            8'd1:    return 8'h80;  // -0
            8'd2:    return 8'h01;
            8'd3:    return 8'h81;
            8'd4:    return 8'h7C;  // E5M2 +inf
            8'd5:    return 8'hFD;  // E5M2 sNaN
            8'd6:    return 8'h7F;
            default: return 8'h7E;
        endcase
    endfunction

    function automatic fpw_req_t rand_req();
        fpw_req_t r;
        r.op        = fp_op_e'(2'(rand_bits(2)));
        r.rm        = 3'(rand_bits(3));
        r.operand_a = rand_operand();
        r.operand_b = (rand_bits(3) == 8'd0) ? r.operand_a : rand_operand();  // Equal pairs
        r.tag       = 4'(rand_bits(4));
        return r;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic fp_fmt_e fmt_of_code(input logic [FMT_CODE_W-1:0] code);
        if (code == FMT_CODE_E4M3) return E4M3;
        if (code == FMT_CODE_E2M1) return E2M1;
        return E5M2;  // Unknown codes too
    endfunction

    function automatic int fp_class(input logic [DATA_W-1:0] v, input fp_fmt_e fmt);
        if (fmt == E2M1) begin
            if (v[2:1] != 2'b00) return C_NORM;
            return v[0] ? C_SUB : C_ZERO;
        end
        if (fmt == E4M3) begin
            if (v[6:0] == 7'h7F) return C_QNAN;  // Only NaN, no inf
            if (v[6:3] != 4'h0) return C_NORM;
            return (v[2:0] != 3'h0) ? C_SUB : C_ZERO;
        end
        if (v[6:2] == 5'h1F) begin
            if (v[1:0] == 2'b00) return C_INF;
            return v[1] ? C_QNAN : C_SNAN;
        end
        if (v[6:2] != 5'h00) return C_NORM;
        return (v[1:0] != 2'b00) ? C_SUB : C_ZERO;
    endfunction

    function automatic logic [RES_W-1:0] fp_pack(input logic s, input logic [MAG_W-1:0] m,
                                                 input fp_fmt_e fmt);
        if (fmt == E2M1) return {6'b0, s, m[2:0]};
        return {2'b0, s, m};
    endfunction

    function automatic fpw_rsp_t ref_rsp(input fpw_req_t r, input logic [FMT_CODE_W-1:0] code);
        fpw_rsp_t         rsp;
        fp_fmt_e          fmt;
        logic             sa, sb, a_nan, b_nan, any_snan, eq, lt;
        logic [MAG_W-1:0] ma, mb;
        logic [1:0]       rm;
        int               ca, cb, ka, kb, idx;
        fmt      = fmt_of_code(code);
        rm       = r.rm[1:0];  // Bit 2 ignored
        sa       = (fmt == E2M1) ? r.operand_a[3] : r.operand_a[7];
        sb       = (fmt == E2M1) ? r.operand_b[3] : r.operand_b[7];
        ma       = (fmt == E2M1) ? {4'b0, r.operand_a[2:0]} : r.operand_a[6:0];
        mb       = (fmt == E2M1) ? {4'b0, r.operand_b[2:0]} : r.operand_b[6:0];
        ca       = fp_class(r.operand_a, fmt);
        cb       = fp_class(r.operand_b, fmt);
        a_nan    = ca >= C_SNAN;
        b_nan    = cb >= C_SNAN;
        any_snan = (ca == C_SNAN) || (cb == C_SNAN);
        ka       = sa ? -2 * int'(ma) - 1 : 2 * int'(ma);  // Ordering key, -0 below +0
        kb       = sb ? -2 * int'(mb) - 1 : 2 * int'(mb);
        eq       = ((ca == C_ZERO) && (cb == C_ZERO)) || (ka == kb);
        lt       = (ka < kb) && !eq;
        rsp      = '0;
        rsp.tag  = r.tag;
        case (r.op)
            FSGNJ: begin
                if (rm == 2'd1)      rsp.result = fp_pack(!sb, ma, fmt);
                else if (rm == 2'd2) rsp.result = fp_pack(sa ^ sb, ma, fmt);
                else                 rsp.result = fp_pack(sb, ma, fmt);
            end
            FMIN_MAX: begin
                if (a_nan && b_nan)
                    rsp.result = {2'b0, (fmt == E4M3) ? CANON_NAN_E4M3 : CANON_NAN_E5M2};
                else if (a_nan)
                    rsp.result = fp_pack(sb, mb, fmt);
                else if (b_nan || (rm[0] ? ka >= kb : ka <= kb))
                    rsp.result = fp_pack(sa, ma, fmt);
                else
                    rsp.result = fp_pack(sb, mb, fmt);
                rsp.status.nv = any_snan;
            end
            FCMP: begin
                if (rm == 2'd0) begin                     // LE
                    rsp.result    = {9'b0, !(a_nan || b_nan) && (lt || eq)};
                    rsp.status.nv = a_nan || b_nan;
                end else if (rm == 2'd1) begin            // LT
                    rsp.result    = {9'b0, !(a_nan || b_nan) && lt};
                    rsp.status.nv = a_nan || b_nan;
                end else begin                            // EQ, quiet
                    rsp.result    = {9'b0, !(a_nan || b_nan) && eq};
                    rsp.status.nv = any_snan;
                end
            end
            default: begin
                idx        = (ca == C_SNAN) ? 8 : (ca == C_QNAN) ? 9 : (sa ? 3 - ca : 4 + ca);
                rsp.result = 10'd1 << idx;
            end
        endcase
        return rsp;
    endfunction

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic fail_run(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_rsp(input fpw_rsp_t got, input fpw_rsp_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: result %h status %b tag %h, expected %h %b %h",
                               $time, got.result, got.status, got.tag,
                               exp.result, exp.status, exp.tag));
    endtask

    task automatic check_fmt(input logic [FMT_CODE_W-1:0] got, input logic [FMT_CODE_W-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: format code %h, expected %h", $time, got, exp));
    endtask

    // Response side scoreboard, sampled mid-cycle
    always @(negedge clk_i) begin
        if (rsp_valid_o && rsp_ready_i) begin
            if (exp_q.size() == 0) begin
                fail_run("a response arrived with no request outstanding");
            end else begin
                check_rsp(rsp_o, exp_q.pop_front());
                issue_cyc = cyc_q.pop_front();
                if (lat_chk && (cycle - issue_cyc != 2))
                    fail_run($sformatf("mismatch at %0t: latency %0d, expected 2",
                                       $time, cycle - issue_cyc));
            end
        end
    end

    // ----------------------------------------
    // Drivers
    // ----------------------------------------
    task automatic tick();
        @(posedge clk_i);
        #10;
        req_valid_i = 1'b0;
        rsp_ready_i = bp_mode ? lfsr_bit() : rsp_hold;
    endtask

    // Offer only when the buffer is in READY, then the item is always taken
    task automatic send_req(input fpw_req_t r);
        tick();
        while (!req_ready_o) begin
            tick();
        end
        req_i       = r;
        req_valid_i = 1'b1;
        @(negedge clk_i);
        if (!req_ready_o) fail_run("req_ready_o dropped while a request was offered");
        exp_q.push_back(ref_rsp(r, cur_code));
        cyc_q.push_back(cycle);
    endtask

    task automatic run_reqs(input int n);
        for (int i = 0; i < n; i++) begin
            if (rand_bits(2) == 8'd0) tick();  // Idle gap
            send_req(rand_req());
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) tick();
    endtask

    // Four-phase write, then read back
    task automatic cfg_write(input logic [FMT_CODE_W-1:0] code);
        tick();
        cfg_req_i   = 1'b1;
        cfg_wdata_i = code;
        do tick(); while (!cfg_ack_o);
        cfg_req_i = 1'b0;
        do tick(); while (cfg_ack_o);
        cur_code = code;
        check_fmt(cfg_fmt_code_o, code);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        cfg_req_i   = 1'b0;
        cfg_wdata_i = '0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b0;
        bp_mode     = 1'b0;
        rsp_hold    = 1'b1;
        lat_chk     = 1'b0;
        cur_code    = FMT_CODE_E5M2;
        repeat (2) @(posedge clk_i);
        #10 rst_ni = 1'b1;
        tick();
        check_fmt(cfg_fmt_code_o, FMT_CODE_E5M2);  // Reset value

        for (int i = 0; i < 4; i++) cfg_write(CODES[i]);

        lat_chk = 1'b1;  // Ready held high, fixed latency
        for (int i = 0; i < 4; i++) begin
            cfg_write(CODES[i]);
            run_reqs(N_PER);
            drain();
        end
        lat_chk = 1'b0;

        bp_mode = 1'b1;  // Random result ready
        for (int i = 0; i < 3; i++) begin
            cfg_write(CODES[i]);
            run_reqs(N_PER);
            drain();
        end
        bp_mode = 1'b0;

        // Fill both stages and the hold register, then flush
        rsp_hold = 1'b0;
        for (int i = 0; i < 3; i++) send_req(rand_req());
        tick();
        flush_i = 1'b1;
        exp_q.delete();
        cyc_q.delete();
        tick();
        flush_i = 1'b0;
        @(negedge clk_i);
        if (rsp_valid_o) fail_run("rsp_valid_o still high after flush");
        if (!req_ready_o) fail_run("req_ready_o low on the cycle after flush");
        rsp_hold = 1'b1;
        repeat (4) tick();  // Any stale response hits the scoreboard
        run_reqs(N_POST);
        drain();

        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "errors were found");
        end
    end

endmodule
